// File: logic/axi_burst_pkg.sv
// ========================================
// AXI burst protocol types
// ========================================

package axi_burst_pkg;

	// Response codes on B and R
	// EXOKAY and DECERR are never produced by this slave
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	// Burst length as carried on awlen/arlen, beats minus one
	typedef logic [7:0] len_t;

	// Longest INCR burst in beats
	localparam int MAX_BEATS = 256;

endpackage

// File: logic/mem_pkg.sv
// ========================================
// Memory word and addressing
// ========================================

package mem_pkg;

	// Low byte address bits dropped to form a word index
	localparam int BYTE_OFFSET = 2;

	// Bytes per word, also the address step per beat
	localparam int WORD_BYTES = 1 << BYTE_OFFSET;

	// Data word and its byte strobe
	typedef logic [8*WORD_BYTES-1:0] word_t;
	typedef logic [WORD_BYTES-1:0]   strb_t;

endpackage

// File: logic/mem_if.sv
// ========================================
// Controller to memory link
// ========================================

`timescale 1ns/100ps

interface mem_if #(
	parameter int MEM_WORDS = 256
);

	localparam int INDEX_WIDTH = $clog2(MEM_WORDS);

	// Write port, one strobed word per cycle
	logic                   wr_en;
	logic [INDEX_WIDTH-1:0] wr_index;
	mem_pkg::word_t         wr_data;
	mem_pkg::strb_t         wr_strb;

	// Read port, rd_data lands one cycle after rd_en
	logic                   rd_en;
	logic [INDEX_WIDTH-1:0] rd_index;
	mem_pkg::word_t         rd_data;

	// Write channel controller side
	modport writer (output wr_en, wr_index, wr_data, wr_strb);

	// Read channel controller side
	modport reader (output rd_en, rd_index, input rd_data);

	// Storage side
	modport array (input wr_en, wr_index, wr_data, wr_strb, rd_en, rd_index, output rd_data);

endinterface

// File: logic/mem_array.sv
// ========================================
// Dual-port word memory
// ========================================

`timescale 1ns/100ps

module mem_array #(
	parameter int MEM_WORDS = 256
) (
	input logic  clk,
	mem_if.array mem
);

	// Word storage, contents undefined until written
	mem_pkg::word_t ram_q [MEM_WORDS];

	// Strobed write, only enabled bytes change
	always_ff @(posedge clk) begin
		if (mem.wr_en) begin
			for (int b = 0; b < mem_pkg::WORD_BYTES; b++) begin
				if (mem.wr_strb[b]) begin
					ram_q[mem.wr_index][8*b +: 8] <= mem.wr_data[8*b +: 8];
				end
			end
		end
	end

	// Registered read port
	// rd_data holds its last value when no read is issued
	always_ff @(posedge clk) begin
		if (mem.rd_en) begin
			mem.rd_data <= ram_q[mem.rd_index];
		end
	end

	// Controllers filter the address range, so no index may run past the depth
	assert property (@(posedge clk) mem.wr_en |-> mem.wr_index < MEM_WORDS)
		else $error("write index %0d beyond memory depth", mem.wr_index);

	assert property (@(posedge clk) mem.rd_en |-> mem.rd_index < MEM_WORDS)
		else $error("read index %0d beyond memory depth", mem.rd_index);

endmodule

// File: logic/axi_write_ctrl.sv
// ========================================
// AXI write channel controller
// ========================================

`timescale 1ns/100ps

module axi_write_ctrl #(
	parameter int ADDR_WIDTH = 16,
	parameter int MEM_WORDS  = 256
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [ADDR_WIDTH-1:0] awaddr,
	input  axi_burst_pkg::len_t   awlen,
	input  logic                  awvalid,
	output logic                  awready,
	input  mem_pkg::word_t        wdata,
	input  mem_pkg::strb_t        wstrb,
	input  logic                  wlast,
	input  logic                  wvalid,
	output logic                  wready,
	input  logic                  bready,
	output axi_burst_pkg::resp_t  bresp,
	output logic                  bvalid,
	mem_if.writer                 mem
);

	localparam int INDEX_WIDTH = $clog2(MEM_WORDS);
	localparam int WORD_BITS   = ADDR_WIDTH - mem_pkg::BYTE_OFFSET + 1;

	// Address step per beat and first word past the memory
	localparam logic [ADDR_WIDTH:0] ADDR_STEP  = (ADDR_WIDTH+1)'(mem_pkg::WORD_BYTES);
	localparam logic [WORD_BITS-1:0] WORD_LIMIT = WORD_BITS'(MEM_WORDS);

	typedef enum logic [1:0] {
		W_IDLE,
		W_DATA,
		W_RESP
	} wr_state_t;

	wr_state_t state_q, state_d;

	// Extra top bit so a burst wrapping the address space reads as out of range
	logic [ADDR_WIDTH:0] addr_q;
	axi_burst_pkg::len_t len_q;
	axi_burst_pkg::len_t beat_q;
	logic                err_q;
	logic                w_fire;
	logic                in_range;
	logic                beat_err;

	assign w_fire   = wvalid && wready;
	assign in_range = addr_q[ADDR_WIDTH:mem_pkg::BYTE_OFFSET] < WORD_LIMIT;

	// Bad beat: outside memory, or wlast not on the announced last beat
	assign beat_err = !in_range || (wlast != (beat_q == len_q));

	always_comb begin
		state_d = state_q;
		case (state_q)
			W_IDLE: if (awvalid && awready) state_d = W_DATA;
			// Burst closes on wlast whatever awlen said
			W_DATA: if (w_fire && wlast) state_d = W_RESP;
			W_RESP: if (bvalid && bready) state_d = W_IDLE;
			default: state_d = W_IDLE;
		endcase
	end

	// Handshake outputs registered from the next state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= W_IDLE;
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			addr_q  <= '0;
			len_q   <= '0;
			beat_q  <= '0;
			err_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			awready <= (state_d == W_IDLE);
			wready  <= (state_d == W_DATA);
			bvalid  <= (state_d == W_RESP);
			if (awvalid && awready) begin
				addr_q <= {1'b0, awaddr};
				len_q  <= awlen;
				beat_q <= '0;
				err_q  <= 1'b0;
			end else if (w_fire) begin
				addr_q <= addr_q + ADDR_STEP;
				beat_q <= beat_q + 8'd1;
				// Sticky until the next AW
				err_q  <= err_q || beat_err;
			end
		end
	end

	assign bresp = err_q ? axi_burst_pkg::RESP_SLVERR : axi_burst_pkg::RESP_OKAY;

	// Memory write on the accepting edge, out-of-range beats dropped
	assign mem.wr_en    = w_fire && in_range;
	assign mem.wr_index = addr_q[mem_pkg::BYTE_OFFSET +: INDEX_WIDTH];
	assign mem.wr_data  = wdata;
	assign mem.wr_strb  = wstrb;

	assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	assert property (@(posedge clk) disable iff (!rst_n) !(wready && bvalid))
		else $error("wready high during write response");

endmodule

// File: logic/axi_read_ctrl.sv
// ========================================
// AXI read channel controller
// ========================================

`timescale 1ns/100ps

module axi_read_ctrl #(
	parameter int ADDR_WIDTH = 16,
	parameter int MEM_WORDS  = 256
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [ADDR_WIDTH-1:0] araddr,
	input  axi_burst_pkg::len_t   arlen,
	input  logic                  arvalid,
	output logic                  arready,
	input  logic                  rready,
	output mem_pkg::word_t        rdata,
	output axi_burst_pkg::resp_t  rresp,
	output logic                  rlast,
	output logic                  rvalid,
	mem_if.reader                 mem
);

	localparam int INDEX_WIDTH = $clog2(MEM_WORDS);
	localparam int WORD_BITS   = ADDR_WIDTH - mem_pkg::BYTE_OFFSET + 1;
	localparam logic [ADDR_WIDTH:0] ADDR_STEP  = (ADDR_WIDTH+1)'(mem_pkg::WORD_BYTES);
	localparam logic [WORD_BITS-1:0] WORD_LIMIT = WORD_BITS'(MEM_WORDS);

	// One R beat with its own response and last flag
	typedef struct packed {
		mem_pkg::word_t       data;
		axi_burst_pkg::resp_t resp;
		logic                 last;
	} beat_t;

	typedef enum logic {
		R_IDLE,
		R_BURST
	} rd_state_t;

	rd_state_t state_q, state_d;

	logic [ADDR_WIDTH:0] addr_q;
	axi_burst_pkg::len_t len_q;
	// Issued count needs 9 bits to pass a 256 beat burst
	logic [8:0]          issued_q;
	axi_burst_pkg::len_t returned_q;
	logic                in_range;
	logic                issue;
	logic                r_fire;

	// Beat whose RAM read completes this cycle
	logic  pipe_valid_q;
	logic  pipe_err_q;
	logic  pipe_last_q;
	beat_t pipe_beat;

	// 2-entry beat buffer for reads that return during a stall
	beat_t      buf_q [2];
	logic       buf_wr_q;
	logic       buf_rd_q;
	logic [1:0] buf_cnt_q;
	logic       push;
	logic       pop;
	logic [1:0] pending;
	beat_t      head;

	assign in_range = addr_q[ADDR_WIDTH:mem_pkg::BYTE_OFFSET] < WORD_LIMIT;

	// Beats held in the buffer plus the one in the RAM stage
	assign pending = buf_cnt_q + {1'b0, pipe_valid_q};
	assign issue   = (state_q == R_BURST) && (issued_q <= {1'b0, len_q}) && (pending < 2'd2);

	// Out-of-range beats never touch the RAM
	assign mem.rd_en    = issue && in_range;
	assign mem.rd_index = addr_q[mem_pkg::BYTE_OFFSET +: INDEX_WIDTH];

	assign pipe_beat.data = pipe_err_q ? '0 : mem.rd_data;
	assign pipe_beat.resp = pipe_err_q ? axi_burst_pkg::RESP_SLVERR : axi_burst_pkg::RESP_OKAY;
	assign pipe_beat.last = pipe_last_q;

	// Buffer head first, RAM stage bypasses when the buffer is empty
	assign head   = (buf_cnt_q != 2'd0) ? buf_q[buf_rd_q] : pipe_beat;
	assign rvalid = (buf_cnt_q != 2'd0) || pipe_valid_q;
	assign rdata  = head.data;
	assign rresp  = head.resp;
	assign rlast  = head.last;
	assign r_fire = rvalid && rready;

	assign pop  = (buf_cnt_q != 2'd0) && rready;
	assign push = pipe_valid_q && !((buf_cnt_q == 2'd0) && rready);

	always_comb begin
		state_d = state_q;
		case (state_q)
			R_IDLE:  if (arvalid && arready) state_d = R_BURST;
			R_BURST: if (r_fire && (returned_q == len_q)) state_d = R_IDLE;
			default: state_d = R_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q      <= R_IDLE;
			arready      <= 1'b0;
			addr_q       <= '0;
			len_q        <= '0;
			issued_q     <= '0;
			returned_q   <= '0;
			pipe_valid_q <= 1'b0;
			pipe_err_q   <= 1'b0;
			pipe_last_q  <= 1'b0;
			buf_wr_q     <= 1'b0;
			buf_rd_q     <= 1'b0;
			buf_cnt_q    <= '0;
		end else begin
			state_q <= state_d;
			arready <= (state_d == R_IDLE);
			if (arvalid && arready) begin
				addr_q     <= {1'b0, araddr};
				len_q      <= arlen;
				issued_q   <= '0;
				returned_q <= '0;
			end else begin
				if (issue) begin
					addr_q   <= addr_q + ADDR_STEP;
					issued_q <= issued_q + 9'd1;
				end
				if (r_fire) returned_q <= returned_q + 8'd1;
			end
			// Flags follow the read through the RAM stage
			pipe_valid_q <= issue;
			pipe_err_q   <= issue && !in_range;
			pipe_last_q  <= issue && (issued_q == {1'b0, len_q});
			if (push) buf_wr_q <= !buf_wr_q;
			if (pop)  buf_rd_q <= !buf_rd_q;
			buf_cnt_q <= buf_cnt_q + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk) begin
		if (push) buf_q[buf_wr_q] <= pipe_beat;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast) && $stable(rresp))
		else $error("R payload changed while stalled");

	assert property (@(posedge clk) disable iff (!rst_n) pending <= 2'd2)
		else $error("more than two reads in flight");

endmodule

// File: logic/axi_mem_top.sv
// ========================================
// AXI4 burst memory slave
// ========================================

`timescale 1ns/100ps

module axi_mem_top #(
	parameter int ADDR_WIDTH = 16,
	parameter int MEM_WORDS  = 256
) (
	input  logic                  clk,
	input  logic                  rst_n,
	// Write address
	input  logic [ADDR_WIDTH-1:0] awaddr,
	input  axi_burst_pkg::len_t   awlen,
	input  logic                  awvalid,
	output logic                  awready,
	// Write data
	input  mem_pkg::word_t        wdata,
	input  mem_pkg::strb_t        wstrb,
	input  logic                  wlast,
	input  logic                  wvalid,
	output logic                  wready,
	// Write response
	output axi_burst_pkg::resp_t  bresp,
	output logic                  bvalid,
	input  logic                  bready,
	// Read address
	input  logic [ADDR_WIDTH-1:0] araddr,
	input  axi_burst_pkg::len_t   arlen,
	input  logic                  arvalid,
	output logic                  arready,
	// Read data
	output mem_pkg::word_t        rdata,
	output axi_burst_pkg::resp_t  rresp,
	output logic                  rlast,
	output logic                  rvalid,
	input  logic                  rready
);

	// Shared by both controllers and the storage
	mem_if #(.MEM_WORDS(MEM_WORDS)) mem_bus ();

	// AW/W/B side, owns the write port
	axi_write_ctrl #(.ADDR_WIDTH(ADDR_WIDTH), .MEM_WORDS(MEM_WORDS)) u_write_ctrl (
		.clk, .rst_n, .awaddr, .awlen, .awvalid, .awready,
		.wdata, .wstrb, .wlast, .wvalid, .wready,
		.bready, .bresp, .bvalid,
		.mem(mem_bus.writer)
	);

	// AR/R side, owns the read port
	axi_read_ctrl #(.ADDR_WIDTH(ADDR_WIDTH), .MEM_WORDS(MEM_WORDS)) u_read_ctrl (
		.clk, .rst_n, .araddr, .arlen, .arvalid, .arready,
		.rready, .rdata, .rresp, .rlast, .rvalid,
		.mem(mem_bus.reader)
	);

	mem_array #(.MEM_WORDS(MEM_WORDS)) u_mem_array (
		.clk,
		.mem(mem_bus.array)
	);

endmodule

// File: testbench/tb_clk_gen.sv
// ========================================
// Testbench clock and reset
// ========================================

`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset low for the first three rising edges, released on an edge
	initial begin
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: testbench/tb_axi_mem.sv
// ========================================
// AXI burst memory testbench
// ========================================

`timescale 1ns/100ps

module tb_axi_mem;

	localparam int ADDR_WIDTH = 16;
	localparam int MEM_WORDS  = 256;
	localparam int MEM_BYTES  = MEM_WORDS << mem_pkg::BYTE_OFFSET;
	localparam int STEP       = 1 << mem_pkg::BYTE_OFFSET;
	// About 70 bursts of up to 16 beats plus stalls
	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] SEED = 32'hf113_b76b;

	logic                  clk;
	logic                  rst_n;
	logic [ADDR_WIDTH-1:0] awaddr;
	axi_burst_pkg::len_t   awlen;
	logic                  awvalid;
	logic                  awready;
	mem_pkg::word_t        wdata;
	mem_pkg::strb_t        wstrb;
	logic                  wlast;
	logic                  wvalid;
	logic                  wready;
	axi_burst_pkg::resp_t  bresp;
	logic                  bvalid;
	logic                  bready;
	logic [ADDR_WIDTH-1:0] araddr;
	axi_burst_pkg::len_t   arlen;
	logic                  arvalid;
	logic                  arready;
	mem_pkg::word_t        rdata;
	axi_burst_pkg::resp_t  rresp;
	logic                  rlast;
	logic                  rvalid;
	logic                  rready;

	// Byte-level reference of the memory
	logic [7:0] model_mem [MEM_BYTES];

	// Burst tracking for the model
	int                   wr_addr_m = 0;
	int                   wr_beat_m = 0;
	int                   wr_len_m  = 0;
	logic                 wr_err_m  = 1'b0;
	logic                 wr_beat_bad;
	axi_burst_pkg::resp_t exp_bresp = axi_burst_pkg::RESP_OKAY;
	int                   rd_addr_m = 0;
	int                   rd_beat_m = 0;
	int                   rd_len_m  = 0;
	logic                 ar_d1 = 1'b0;
	logic                 ar_d2 = 1'b0;
	mem_pkg::word_t       exp_rdata;
	axi_burst_pkg::resp_t exp_rresp;
	logic                 exp_rlast;

	int errors = 0;
	int tests  = 0;
	int checks = 0;
	int cycles = 0;
	bit stall_mode = 1'b0;

	tb_clk_gen u_clk_gen (.clk, .rst_n);

	axi_mem_top dut (
		.clk, .rst_n, .awaddr, .awlen, .awvalid, .awready,
		.wdata, .wstrb, .wlast, .wvalid, .wready, .bresp, .bvalid, .bready,
		.araddr, .arlen, .arvalid, .arready, .rdata, .rresp, .rlast, .rvalid, .rready
	);

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s finished, %0d errors so far", name, errors);
	endtask

	// Outside the memory or wlast not on the beat awlen announced
	assign wr_beat_bad = (wr_addr_m >= MEM_BYTES) || (wlast != (wr_beat_m == wr_len_m));

	// Follow accepted transfers and update the model
	always @(posedge clk) begin
		if (awvalid && awready) begin
			wr_addr_m <= int'(awaddr);
			wr_beat_m <= 0;
			wr_len_m  <= int'(awlen);
			wr_err_m  <= 1'b0;
		end else if (wvalid && wready) begin
			for (int b = 0; b < STEP; b++) begin
				if (wstrb[b] && wr_addr_m < MEM_BYTES)
					model_mem[wr_addr_m + b] <= wdata[8*b +: 8];
			end
			if (wlast)
				exp_bresp <= (wr_err_m || wr_beat_bad) ? axi_burst_pkg::RESP_SLVERR :
					axi_burst_pkg::RESP_OKAY;
			wr_err_m  <= wr_err_m || wr_beat_bad;
			wr_addr_m <= wr_addr_m + STEP;
			wr_beat_m <= wr_beat_m + 1;
		end
		if (arvalid && arready) begin
			rd_addr_m <= int'(araddr);
			rd_beat_m <= 0;
			rd_len_m  <= int'(arlen);
		end else if (rvalid && rready) begin
			rd_addr_m <= rd_addr_m + STEP;
			rd_beat_m <= rd_beat_m + 1;
		end
		checks <= checks + int'(rvalid && rready) + int'(bvalid && bready);
		ar_d1  <= arvalid && arready;
		ar_d2  <= ar_d1;
	end

	// Expected R beat with zero data and SLVERR past the memory
	always_comb begin
		exp_rresp = (rd_addr_m < MEM_BYTES) ? axi_burst_pkg::RESP_OKAY :
			axi_burst_pkg::RESP_SLVERR;
		exp_rlast = (rd_beat_m == rd_len_m);
		exp_rdata = '0;
		if (rd_addr_m < MEM_BYTES) begin
			for (int b = 0; b < STEP; b++) exp_rdata[8*b +: 8] = model_mem[rd_addr_m + b];
		end
	end

	// Checks sampled on the falling edge where every signal is settled
	assert property (@(negedge clk) (!rst_n || $rose(rst_n)) |->
		!awready && !wready && !bvalid && !arready && !rvalid && !rlast)
		else report_failure("handshake output high during or at the end of reset");
	assert property (@(negedge clk) $rose(rst_n) |=> awready && arready)
		else report_failure("awready or arready did not rise the cycle after reset");
	assert property (@(negedge clk) disable iff (!rst_n) rvalid && rready |-> rdata == exp_rdata)
		else report_mismatch("rdata", rdata, exp_rdata);
	assert property (@(negedge clk) disable iff (!rst_n) rvalid && rready |-> rresp == exp_rresp)
		else report_mismatch("rresp", 32'(rresp), 32'(exp_rresp));
	assert property (@(negedge clk) disable iff (!rst_n) rvalid && rready |-> rlast == exp_rlast)
		else report_mismatch("rlast", 32'(rlast), 32'(exp_rlast));
	assert property (@(negedge clk) disable iff (!rst_n) bvalid |-> bresp == exp_bresp)
		else report_mismatch("bresp", 32'(bresp), 32'(exp_bresp));
	assert property (@(negedge clk) disable iff (!rst_n) rvalid && !rready |=>
		rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast))
		else report_failure("R payload changed while rready was low");
	assert property (@(negedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
		else report_failure("bvalid dropped before bready");
	// First beat exactly two cycles after the AR transfer
	assert property (@(negedge clk) disable iff (!rst_n) ar_d1 |-> !rvalid)
		else report_failure("rvalid came one cycle after the AR transfer");
	assert property (@(negedge clk) disable iff (!rst_n) ar_d2 |-> rvalid)
		else report_failure("rvalid missing two cycles after the AR transfer");

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	// Random stalls only while stall_mode is set
	task automatic drive_readies();
		forever begin
			@(posedge clk);
			rready <= !stall_mode || ($urandom_range(2) != 0);
			bready <= !stall_mode || ($urandom_range(1) != 0);
		end
	endtask

	task automatic write_burst(input int addr, input int len, input int last_at,
		input bit rand_strb);
		awaddr  <= ADDR_WIDTH'(addr);
		awlen   <= axi_burst_pkg::len_t'(len);
		awvalid <= 1'b1;
		do @(posedge clk); while (!awready);
		awvalid <= 1'b0;
		for (int i = 0; i <= last_at; i++) begin
			wdata  <= $urandom;
			wstrb  <= rand_strb ? mem_pkg::strb_t'($urandom) : '1;
			wlast  <= (i == last_at);
			wvalid <= 1'b1;
			do @(posedge clk); while (!wready);
		end
		wvalid <= 1'b0;
		wlast  <= 1'b0;
		do @(posedge clk); while (!(bvalid && bready));
	endtask

	task automatic read_burst(input int addr, input int len);
		araddr  <= ADDR_WIDTH'(addr);
		arlen   <= axi_burst_pkg::len_t'(len);
		arvalid <= 1'b1;
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		do @(posedge clk); while (!(rvalid && rready && rlast));
	endtask

	initial begin
		int len;
		int addr;
		void'($urandom(SEED));
		awaddr  <= '0;
		awlen   <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		wlast   <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= 1'b0;
		araddr  <= '0;
		arlen   <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b0;
		fork
			drive_readies();
		join_none
		wait (rst_n);
		repeat (3) @(posedge clk);
		end_test("reset");
		// Fill the whole memory with 16-beat bursts, then read it all back
		for (int a = 0; a < MEM_BYTES; a += 16 * STEP) write_burst(a, 15, 15, 1'b0);
		for (int a = 0; a < MEM_BYTES; a += 16 * STEP) read_burst(a, 15);
		end_test("full bursts");
		write_burst(32'h100, 7, 7, 1'b1);
		read_burst(32'h100, 7);
		end_test("byte strobes");
		// Address wraps in 16 bits so word 0 must stay untouched
		write_burst(32'hfff8, 3, 3, 1'b0);
		read_burst(32'h000, 3);
		read_burst(32'h3f8, 3);
		read_burst(32'h800, 1);
		end_test("out of range");
		write_burst(32'h080, 7, 3, 1'b0);
		read_burst(32'h080, 7);
		end_test("early wlast");
		stall_mode <= 1'b1;
		repeat (16) begin
			len  = int'($urandom_range(15));
			addr = int'($urandom_range(MEM_WORDS - 1 - len)) * STEP;
			write_burst(addr, len, len, 1'b1);
			read_burst(addr, len);
		end
		stall_mode <= 1'b0;
		end_test("back-pressure");
		repeat (2) @(posedge clk);
		$display("tests %0d, responses checked %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: files.f
logic/axi_burst_pkg.sv
logic/mem_pkg.sv
logic/mem_if.sv
logic/mem_array.sv
logic/axi_write_ctrl.sv
logic/axi_read_ctrl.sv
logic/axi_mem_top.sv
testbench/tb_clk_gen.sv
testbench/tb_axi_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI burst memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module tb_axi_mem -o tb_axi_mem > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_axi_mem > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^All checks passed$" "$SIM_LOG"; then
	exit 0
fi
exit 1
